// File: src/hacd_pkg.sv
/*
 * shared widths, bus structs and enums for the bring-up core
 * every memory access is a single 64-bit beat, no bursts or ids
 * strobe is carried on the write beat only, page writes imply full strobe
 * module parameters (table and list placement) live in hacd_core
 */
package hacd_pkg;

   ////////////////////
   // widths
   ////////////////////
   localparam int addr_w = 32;
   localparam int data_w = 64;
   localparam int strb_w = 8;

   // end-of-list marker in the free page list
   localparam logic [data_w-1:0] null_ptr = '1;

   ////////////////////
   // memory bus packets
   ////////////////////

   // one write beat toward the memory controller
   typedef struct packed {
      logic [addr_w-1:0] addr;
      logic [data_w-1:0] data;
      logic [strb_w-1:0] strb;
   } mem_wr_req_t;

   // one read request
   typedef struct packed {
      logic [addr_w-1:0] addr;
   } mem_rd_req_t;

   // read data back, resp is the usual 2-bit okay/error code
   typedef struct packed {
      logic [data_w-1:0] data;
      logic [1:0]        resp;
   } mem_rd_resp_t;

   // page write from manager to write master
   typedef struct packed {
      logic [addr_w-1:0] addr;
      logic [data_w-1:0] data;
   } pgwr_req_t;

   ////////////////////
   // states and opcodes
   ////////////////////
   typedef enum logic [2:0] {
      st_reset,
      st_init_att,
      st_init_list,
      st_run
   } ctrl_state_e;

   typedef enum logic [1:0] {
      op_none,
      op_clear_att,
      op_build_list
   } init_op_e;

endpackage

// File: src/hacd_ctrl_unit.sv
/*
 * top control FSM of the bring-up core
 * runs table clear then free list build, one start pulse per phase
 * cpu_sel rises once on entering run and never falls again
 * no runtime cpu hold, the memory port stays with the cpu after init
 */
`timescale 1ns/1ps

module hacd_ctrl_unit (
   input  logic               clk_i,
   input  logic               rst_n,
   input  logic               phase_done,
   output logic               start,
   output hacd_pkg::init_op_e init_op,
   output logic               cpu_sel
);
   import hacd_pkg::*;

   ctrl_state_e state;
   ctrl_state_e state_nxt;
   init_op_e    op_nxt;

   ////////////////////
   // next state
   ////////////////////
   always_comb begin
      state_nxt = state;
      case (state)
         // leave reset on the first clock
         st_reset: begin
            state_nxt = st_init_att;
         end
         st_init_att: begin
            if (phase_done) begin
               state_nxt = st_init_list;
            end
         end
         st_init_list: begin
            if (phase_done) begin
               state_nxt = st_run;
            end
         end
         // run is terminal
         st_run: begin
            state_nxt = st_run;
         end
         default: begin
            state_nxt = st_reset;
         end
      endcase
   end

   // opcode that belongs to the state being entered
   always_comb begin
      case (state_nxt)
         st_init_att:  op_nxt = op_clear_att;
         st_init_list: op_nxt = op_build_list;
         default:      op_nxt = op_none;
      endcase
   end

   ////////////////////
   // registered outputs
   ////////////////////
   always_ff @(posedge clk_i or negedge rst_n) begin
      if (!rst_n) begin
         state   <= st_reset;
         start   <= 1'b0;
         init_op <= op_none;
         cpu_sel <= 1'b0;
      end else begin
         state   <= state_nxt;
         // start only on a transition into an init phase
         start   <= (state_nxt != state) && (op_nxt != op_none);
         init_op <= op_nxt;
         // hand memory to the cpu once init is over
         cpu_sel <= (state_nxt == st_run);
      end
   end

endmodule

// File: src/hacd_pgwr_mngr.sv
/*
 * page write manager, generates the init write streams
 * op_clear_att: att_entries zero words from att_base
 * op_build_list: num_pages entries from list_base, entry i holds i+1,
 * last entry holds null_ptr
 * start must not arrive while a phase is still running
 */
`timescale 1ns/1ps

module hacd_pgwr_mngr #(
   parameter logic [hacd_pkg::addr_w-1:0] att_base    = 32'h0000_1000,
   parameter int unsigned                 att_entries = 8,
   parameter logic [hacd_pkg::addr_w-1:0] list_base   = 32'h0000_2000,
   parameter int unsigned                 num_pages   = 16
) (
   input  logic                clk_i,
   input  logic                rst_n,
   input  logic                start,
   input  hacd_pkg::init_op_e  init_op,
   output hacd_pkg::pgwr_req_t pg_req,
   output logic                pg_valid,
   input  logic                pg_ready,
   input  logic                wr_ack,
   output logic                phase_done
);
   import hacd_pkg::*;

   // counters sized for the longer of the two phases
   localparam int max_n = (att_entries > num_pages) ? att_entries : num_pages;
   localparam int cnt_w = $clog2(max_n + 1);

   init_op_e          op_q;
   logic              active;
   logic [cnt_w-1:0]  total;
   logic [cnt_w-1:0]  issue_cnt;
   logic [cnt_w-1:0]  ack_cnt;
   logic [addr_w-1:0] base_addr;
   logic              last_ack;

   ////////////////////
   // request generation
   ////////////////////

   // keep issuing until every write of the phase is out
   assign pg_valid = active && (issue_cnt != total);
   assign last_ack = active && wr_ack && (ack_cnt == total - cnt_w'(1));

   always_comb begin
      base_addr   = (op_q == op_clear_att) ? att_base : list_base;
      // one 8-byte word per index
      pg_req.addr = base_addr + (addr_w'(issue_cnt) << 3);
      if (op_q == op_clear_att) begin
         pg_req.data = '0;
      end else if (issue_cnt == cnt_w'(num_pages - 1)) begin
         pg_req.data = null_ptr;
      end else begin
         // link to the next page
         pg_req.data = data_w'(issue_cnt) + data_w'(1);
      end
   end

   ////////////////////
   // phase bookkeeping
   ////////////////////
   always_ff @(posedge clk_i or negedge rst_n) begin
      if (!rst_n) begin
         op_q       <= op_none;
         active     <= 1'b0;
         total      <= '0;
         issue_cnt  <= '0;
         ack_cnt    <= '0;
         phase_done <= 1'b0;
      end else begin
         phase_done <= 1'b0;
         if (start) begin
            // latch opcode and length of the new phase
            op_q      <= init_op;
            active    <= (init_op != op_none);
            total     <= (init_op == op_clear_att) ? cnt_w'(att_entries) : cnt_w'(num_pages);
            issue_cnt <= '0;
            ack_cnt   <= '0;
         end else begin
            if (pg_valid && pg_ready) begin
               issue_cnt <= issue_cnt + cnt_w'(1);
            end
            if (active && wr_ack) begin
               ack_cnt <= ack_cnt + cnt_w'(1);
            end
            // all acks back, phase over
            if (last_ack) begin
               active     <= 1'b0;
               phase_done <= 1'b1;
            end
         end
      end
   end

endmodule

// File: src/hacd_wr_master.sv
/*
 * write master, single register stage without skid buffer
 * widens each page write into a full-strobe memory beat
 * ready is combinational from the downstream ready
 * acks are forwarded one cycle after the memory response
 */
`timescale 1ns/1ps

module hacd_wr_master (
   input  logic                  clk_i,
   input  logic                  rst_n,
   input  hacd_pkg::pgwr_req_t   pg_req,
   input  logic                  pg_valid,
   output logic                  pg_ready,
   output hacd_pkg::mem_wr_req_t hk_wr,
   output logic                  hk_wr_valid,
   input  logic                  hk_wr_ready,
   input  logic                  hk_bvalid,
   output logic                  wr_ack
);

   logic load;

   ////////////////////
   // beat register
   ////////////////////

   // free slot, or the held beat leaves this cycle
   assign pg_ready = !hk_wr_valid || hk_wr_ready;
   assign load     = pg_valid && pg_ready;

   always_ff @(posedge clk_i or negedge rst_n) begin
      if (!rst_n) begin
         hk_wr_valid <= 1'b0;
      end else if (pg_ready) begin
         hk_wr_valid <= pg_valid;
      end
   end

   // payload only moves on a real transfer
   always_ff @(posedge clk_i) begin
      if (load) begin
         hk_wr.addr <= pg_req.addr;
         hk_wr.data <= pg_req.data;
         // page writes always cover the whole word
         hk_wr.strb <= '1;
      end
   end

   ////////////////////
   // ack return
   ////////////////////
   always_ff @(posedge clk_i or negedge rst_n) begin
      if (!rst_n) begin
         wr_ack <= 1'b0;
      end else begin
         wr_ack <= hk_bvalid;
      end
   end

endmodule

// File: src/hacd_mem_mux.sv
/*
 * registered 2:1 mux toward the memory controller
 * plain select by cpu_sel, one owner at a time, no arbitration
 * the owner must have no write in flight when cpu_sel changes
 * responses are routed combinationally and assumed in order
 * the accelerator never reads, read path is cpu only
 */
`timescale 1ns/1ps

module hacd_mem_mux (
   input  logic                   clk_i,
   input  logic                   rst_n,
   input  logic                   cpu_sel,
   // accelerator write side
   input  hacd_pkg::mem_wr_req_t  hk_wr,
   input  logic                   hk_wr_valid,
   output logic                   hk_wr_ready,
   output logic                   hk_bvalid,
   // cpu side
   input  hacd_pkg::mem_wr_req_t  cpu_wr,
   input  logic                   cpu_wr_valid,
   output logic                   cpu_wr_ready,
   output logic                   cpu_bvalid,
   input  hacd_pkg::mem_rd_req_t  cpu_rd,
   input  logic                   cpu_rd_valid,
   output logic                   cpu_rd_ready,
   output hacd_pkg::mem_rd_resp_t cpu_rresp,
   output logic                   cpu_rresp_valid,
   // memory controller side
   output hacd_pkg::mem_wr_req_t  mc_wr,
   output logic                   mc_wr_valid,
   input  logic                   mc_wr_ready,
   input  logic                   mc_bvalid,
   output hacd_pkg::mem_rd_req_t  mc_rd,
   output logic                   mc_rd_valid,
   input  logic                   mc_rd_ready,
   input  hacd_pkg::mem_rd_resp_t mc_rresp,
   input  logic                   mc_rresp_valid
);
   import hacd_pkg::*;

   mem_wr_req_t wr_src;
   logic        wr_src_valid;
   logic        wr_slot_free;
   logic        rd_slot_free;

   ////////////////////
   // write channel
   ////////////////////
   assign wr_src       = cpu_sel ? cpu_wr : hk_wr;
   assign wr_src_valid = cpu_sel ? cpu_wr_valid : hk_wr_valid;
   assign wr_slot_free = !mc_wr_valid || mc_wr_ready;

   // unselected side sees ready low
   assign hk_wr_ready  = !cpu_sel && wr_slot_free;
   assign cpu_wr_ready = cpu_sel && wr_slot_free;

   always_ff @(posedge clk_i or negedge rst_n) begin
      if (!rst_n) begin
         mc_wr_valid <= 1'b0;
      end else if (wr_slot_free) begin
         mc_wr_valid <= wr_src_valid;
      end
   end

   always_ff @(posedge clk_i) begin
      if (wr_slot_free && wr_src_valid) begin
         mc_wr <= wr_src;
      end
   end

   ////////////////////
   // read channel
   ////////////////////
   assign rd_slot_free = !mc_rd_valid || mc_rd_ready;
   // cpu reads blocked until init is done
   assign cpu_rd_ready = cpu_sel && rd_slot_free;

   always_ff @(posedge clk_i or negedge rst_n) begin
      if (!rst_n) begin
         mc_rd_valid <= 1'b0;
      end else if (rd_slot_free) begin
         mc_rd_valid <= cpu_sel && cpu_rd_valid;
      end
   end

   always_ff @(posedge clk_i) begin
      if (cpu_rd_ready && cpu_rd_valid) begin
         mc_rd <= cpu_rd;
      end
   end

   ////////////////////
   // response routing
   ////////////////////
   assign hk_bvalid       = mc_bvalid && !cpu_sel;
   assign cpu_bvalid      = mc_bvalid && cpu_sel;
   assign cpu_rresp       = mc_rresp;
   assign cpu_rresp_valid = mc_rresp_valid;

endmodule

// File: src/hacd_core.sv
/*
 * top level of the bring-up core, wiring only
 * init clears the attribute table and builds the free list,
 * then memory is handed to the cpu and init_done stays high
 * cpu ready outputs are low until init_done
 */
`timescale 1ns/1ps

module hacd_core #(
   parameter logic [hacd_pkg::addr_w-1:0] att_base    = 32'h0000_1000,
   parameter int unsigned                 att_entries = 8,
   parameter logic [hacd_pkg::addr_w-1:0] list_base   = 32'h0000_2000,
   parameter int unsigned                 num_pages   = 16
) (
   input  logic                   clk_i,
   input  logic                   rst_n,
   // cpu
   input  hacd_pkg::mem_wr_req_t  cpu_wr,
   input  logic                   cpu_wr_valid,
   output logic                   cpu_wr_ready,
   output logic                   cpu_bvalid,
   input  hacd_pkg::mem_rd_req_t  cpu_rd,
   input  logic                   cpu_rd_valid,
   output logic                   cpu_rd_ready,
   output hacd_pkg::mem_rd_resp_t cpu_rresp,
   output logic                   cpu_rresp_valid,
   // memory controller
   output hacd_pkg::mem_wr_req_t  mc_wr,
   output logic                   mc_wr_valid,
   input  logic                   mc_wr_ready,
   input  logic                   mc_bvalid,
   output hacd_pkg::mem_rd_req_t  mc_rd,
   output logic                   mc_rd_valid,
   input  logic                   mc_rd_ready,
   input  hacd_pkg::mem_rd_resp_t mc_rresp,
   input  logic                   mc_rresp_valid,
   output logic                   init_done
);
   import hacd_pkg::*;

   // control unit to manager
   logic        start;
   logic        phase_done;
   init_op_e    init_op;
   logic        cpu_sel;
   // manager to write master
   pgwr_req_t   pg_req;
   logic        pg_valid;
   logic        pg_ready;
   logic        wr_ack;
   // write master to mux
   mem_wr_req_t hk_wr;
   logic        hk_wr_valid;
   logic        hk_wr_ready;
   logic        hk_bvalid;

   assign init_done = cpu_sel;

   hacd_ctrl_unit u_ctrl_unit (.*);

   hacd_pgwr_mngr #(
      .att_base    (att_base),
      .att_entries (att_entries),
      .list_base   (list_base),
      .num_pages   (num_pages)
   ) u_pgwr_mngr (.*);

   hacd_wr_master u_wr_master (.*);

   hacd_mem_mux u_mem_mux (.*);

endmodule

// File: test/hacd_core_assertions.sv
/*
 * protocol assertions bound into every hacd_core instance
 * sampled on the rising clock of clk_i
 * stability and blocking checks are off while rst_n is low
 * init_done is expected to rise once and stay high
 */
`timescale 1ns/1ps

module hacd_core_assertions (
   input logic                  clk_i,
   input logic                  rst_n,
   input hacd_pkg::mem_wr_req_t mc_wr,
   input logic                  mc_wr_valid,
   input logic                  mc_wr_ready,
   input logic                  mc_rd_valid,
   input logic                  cpu_wr_ready,
   input logic                  cpu_rd_ready,
   input logic                  cpu_bvalid,
   input logic                  init_done
);

   ////////////////////
   // memory write channel
   ////////////////////

   // a stalled beat stays put until the controller takes it
   property wr_hold_p;
      @(posedge clk_i) disable iff (!rst_n)
         (mc_wr_valid && !mc_wr_ready) |=> (mc_wr_valid && $stable(mc_wr));
   endproperty
   wr_hold_a: assert property (wr_hold_p)
      else $error("mc write beat changed or dropped before mc_wr_ready");

   ////////////////////
   // init sequencing
   ////////////////////

   // cpu locked out until init is over
   property cpu_blocked_p;
      @(posedge clk_i) disable iff (!rst_n)
         !init_done |-> (!cpu_wr_ready && !cpu_rd_ready);
   endproperty
   cpu_blocked_a: assert property (cpu_blocked_p)
      else $error("cpu ready high before init_done");

   // nothing valid while in reset
   property reset_quiet_p;
      @(posedge clk_i)
         !rst_n |-> (!mc_wr_valid && !mc_rd_valid && !cpu_bvalid && !init_done);
   endproperty
   reset_quiet_a: assert property (reset_quiet_p)
      else $error("valid output or init_done high during reset");

   // hand-over is one way
   property init_sticky_p;
      @(posedge clk_i) disable iff (!rst_n)
         init_done |=> init_done;
   endproperty
   init_sticky_a: assert property (init_sticky_p)
      else $error("init_done fell after it had risen");

endmodule

bind hacd_core hacd_core_assertions i_assertions (.*);

// File: test/hacd_core_tb.sv
/*
 * testbench for hacd_core: init checks, then a cpu table run
 * memory controller model is a sparse word memory, responses 2 cycles
 * after acceptance and in order, mc readies random with a fixed seed
 * inputs change 1 ns after the rising edge, outputs sampled on falling edge
 * one cpu request in flight at a time
 */
`timescale 1ns/1ps

module hacd_core_tb;
   import hacd_pkg::*;

   localparam logic [31:0] att_base    = 32'h0000_1000;
   localparam int          att_entries = 8;
   localparam logic [31:0] list_base   = 32'h0000_2000;
   localparam int          num_pages   = 16;
   localparam int          num_tests   = 10;
   // generous bound on total run length
   localparam int          timeout_cycles = 20 * (att_entries + num_pages + num_tests);

   typedef enum logic {op_wr, op_rd} cpu_op_e;

   typedef struct {
      string       name;
      cpu_op_e     op;
      logic [31:0] addr;
      logic [63:0] data;
      logic [63:0] expected;
   } test_entry_t;

   logic         clk_i;
   logic         rst_n;
   mem_wr_req_t  cpu_wr;
   logic         cpu_wr_valid;
   logic         cpu_wr_ready;
   logic         cpu_bvalid;
   mem_rd_req_t  cpu_rd;
   logic         cpu_rd_valid;
   logic         cpu_rd_ready;
   mem_rd_resp_t cpu_rresp;
   logic         cpu_rresp_valid;
   mem_wr_req_t  mc_wr;
   logic         mc_wr_valid;
   logic         mc_wr_ready;
   logic         mc_bvalid;
   mem_rd_req_t  mc_rd;
   logic         mc_rd_valid;
   logic         mc_rd_ready;
   mem_rd_resp_t mc_rresp;
   logic         mc_rresp_valid;
   logic         init_done;

   // model state
   logic [63:0]  mem [logic [31:0]];
   integer       seed;
   int           mc_wr_cnt;
   int           init_wr_cnt;
   int           cpu_b_cnt;
   int           cpu_r_cnt;
   int           cycle_cnt;
   // bookkeeping
   test_entry_t  tests [num_tests];
   logic         test_ok;
   int           pass_cnt;
   int           fail_cnt;

   hacd_core #(
      .att_base    (att_base),
      .att_entries (att_entries),
      .list_base   (list_base),
      .num_pages   (num_pages)
   ) i_dut (.*);

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   ////////////////////
   // memory controller model
   ////////////////////
   initial begin : mem_model
      logic        wr_fire;
      logic        rd_fire;
      logic [63:0] word;
      logic [63:0] rd_word;
      logic [1:0]  b_pipe;
      logic [1:0]  r_pipe;
      logic [63:0] r_data [2];
      seed           = 32'h8d2f_cd3e;
      mc_wr_ready    = 1'b0;
      mc_rd_ready    = 1'b0;
      mc_bvalid      = 1'b0;
      mc_rresp       = '0;
      mc_rresp_valid = 1'b0;
      b_pipe         = '0;
      r_pipe         = '0;
      rd_word        = '0;
      r_data[0]      = '0;
      r_data[1]      = '0;
      forever begin
         @(negedge clk_i);
         wr_fire = rst_n && mc_wr_valid && mc_wr_ready;
         rd_fire = rst_n && mc_rd_valid && mc_rd_ready;
         if (wr_fire) begin
            word = mem.exists(mc_wr.addr) ? mem[mc_wr.addr] : 64'h0;
            // byte lanes under the strobe only
            for (int b = 0; b < 8; b++) begin
               if (mc_wr.strb[b]) begin
                  word[8*b +: 8] = mc_wr.data[8*b +: 8];
               end
            end
            mem[mc_wr.addr] = word;
            mc_wr_cnt++;
            if (!init_done) begin
               init_wr_cnt++;
            end
         end
         if (rd_fire) begin
            rd_word = mem.exists(mc_rd.addr) ? mem[mc_rd.addr] : 64'h0;
         end
         if (cpu_bvalid) begin
            cpu_b_cnt++;
         end
         if (cpu_rresp_valid) begin
            cpu_r_cnt++;
         end
         @(posedge clk_i);
         #1;
         // two-deep pipes give the 2 cycle response latency
         b_pipe         = {b_pipe[0], wr_fire};
         r_pipe         = {r_pipe[0], rd_fire};
         r_data[1]      = r_data[0];
         r_data[0]      = rd_word;
         mc_bvalid      = b_pipe[1];
         mc_rresp_valid = r_pipe[1];
         mc_rresp.data  = r_data[1];
         mc_rresp.resp  = 2'b00;
         mc_wr_ready    = rst_n && (($random(seed) & 3) != 0);
         mc_rd_ready    = rst_n && (($random(seed) & 3) != 0);
      end
   end

   ////////////////////
   // check helpers
   ////////////////////
   task automatic start_test;
      test_ok = 1'b1;
   endtask

   task automatic end_test(input string name);
      if (test_ok) begin
         pass_cnt++;
         $display("test %-14s ok", name);
      end else begin
         fail_cnt++;
         $display("test %-14s failed", name);
      end
   endtask

   task automatic check_value(input string name, input logic [63:0] exp,
                              input logic [63:0] act);
      assert (act === exp) else begin
         $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
         test_ok = 1'b0;
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      assert (cond) else begin
         $display("error: %s", what);
         test_ok = 1'b0;
      end
   endtask

   ////////////////////
   // cpu side
   ////////////////////

   // one write, returns after its cpu_bvalid
   task automatic cpu_write(input logic [31:0] addr, input logic [63:0] data);
      logic done;
      done = 1'b0;
      @(posedge clk_i);
      #1;
      cpu_wr.addr  = addr;
      cpu_wr.data  = data;
      cpu_wr.strb  = 8'hff;
      cpu_wr_valid = 1'b1;
      while (!done) begin
         @(negedge clk_i);
         done = cpu_wr_ready;
         @(posedge clk_i);
      end
      #1;
      cpu_wr_valid = 1'b0;
      done = 1'b0;
      while (!done) begin
         @(negedge clk_i);
         done = cpu_bvalid;
      end
   endtask

   // one read, returns the whole response
   task automatic cpu_read(input logic [31:0] addr, output mem_rd_resp_t resp);
      logic done;
      done = 1'b0;
      @(posedge clk_i);
      #1;
      cpu_rd.addr  = addr;
      cpu_rd_valid = 1'b1;
      while (!done) begin
         @(negedge clk_i);
         done = cpu_rd_ready;
         @(posedge clk_i);
      end
      #1;
      cpu_rd_valid = 1'b0;
      done = 1'b0;
      while (!done) begin
         @(negedge clk_i);
         done = cpu_rresp_valid;
      end
      resp = cpu_rresp;
   endtask

   // hold cpu valids high through init, readies must stay low
   task automatic run_block_test;
      logic done;
      start_test();
      done = 1'b0;
      @(posedge clk_i);
      #1;
      cpu_wr.addr  = 32'h0000_dea0;
      cpu_wr.data  = 64'hbad0_bad0_bad0_bad0;
      cpu_wr.strb  = 8'hff;
      cpu_rd.addr  = 32'h0000_dea0;
      cpu_wr_valid = 1'b1;
      cpu_rd_valid = 1'b1;
      while (!done) begin
         @(negedge clk_i);
         check_value("cpu_block", 64'h0, 64'({cpu_wr_ready, cpu_rd_ready}));
         @(posedge clk_i);
         #1;
         done = init_done;
      end
      // drop before the first cycle the mux could accept
      cpu_wr_valid = 1'b0;
      cpu_rd_valid = 1'b0;
      end_test("cpu_block");
   endtask

   task automatic load_table;
      tests[0] = '{"wr_att_0",   op_wr, 32'h0000_1000, 64'h1111_2222_3333_4444,
                   64'h1111_2222_3333_4444};
      tests[1] = '{"rd_att_0",   op_rd, 32'h0000_1000, 64'h0, 64'h1111_2222_3333_4444};
      // untouched words still hold init values
      tests[2] = '{"rd_att_5",   op_rd, 32'h0000_1028, 64'h0, 64'h0};
      tests[3] = '{"rd_list_3",  op_rd, 32'h0000_2018, 64'h0, 64'h4};
      tests[4] = '{"rd_list_15", op_rd, 32'h0000_2078, 64'h0, 64'hffff_ffff_ffff_ffff};
      tests[5] = '{"wr_list_3",  op_wr, 32'h0000_2018, 64'hdead_beef_0000_0001,
                   64'hdead_beef_0000_0001};
      tests[6] = '{"wr_list_3b", op_wr, 32'h0000_2018, 64'h0123_4567_89ab_cdef,
                   64'h0123_4567_89ab_cdef};
      // last write wins
      tests[7] = '{"rd_list_3b", op_rd, 32'h0000_2018, 64'h0, 64'h0123_4567_89ab_cdef};
      tests[8] = '{"wr_high",    op_wr, 32'h8000_0040, 64'ha5a5_5a5a_a5a5_5a5a,
                   64'ha5a5_5a5a_a5a5_5a5a};
      tests[9] = '{"rd_high",    op_rd, 32'h8000_0040, 64'h0, 64'ha5a5_5a5a_a5a5_5a5a};
   endtask

   ////////////////////
   // main sequence
   ////////////////////
   initial begin : main
      logic [31:0]  addr;
      mem_rd_resp_t rd_resp;
      int           n_wr;
      int           n_rd;
      rst_n        = 1'b0;
      cpu_wr       = '0;
      cpu_wr_valid = 1'b0;
      cpu_rd       = '0;
      cpu_rd_valid = 1'b0;
      mc_wr_cnt    = 0;
      init_wr_cnt  = 0;
      cpu_b_cnt    = 0;
      cpu_r_cnt    = 0;
      pass_cnt     = 0;
      fail_cnt     = 0;
      n_wr         = 0;
      n_rd         = 0;
      load_table();
      repeat (4) @(posedge clk_i);
      #1;
      rst_n = 1'b1;

      run_block_test();

      // table region cleared
      start_test();
      for (int i = 0; i < att_entries; i++) begin
         addr = att_base + 32'(8 * i);
         check_true(mem.exists(addr), $sformatf("no init write seen at %h", addr));
         if (mem.exists(addr)) begin
            check_value($sformatf("att_clear %h", addr), 64'h0, mem[addr]);
         end
      end
      end_test("att_clear");

      // linked free list, last entry ends the chain
      start_test();
      for (int i = 0; i < num_pages; i++) begin
         addr = list_base + 32'(8 * i);
         check_true(mem.exists(addr), $sformatf("no init write seen at %h", addr));
         if (mem.exists(addr)) begin
            check_value($sformatf("free_list %h", addr),
                        (i == num_pages - 1) ? {64{1'b1}} : 64'(i + 1), mem[addr]);
         end
      end
      check_value("free_list init_writes", 64'(att_entries + num_pages), 64'(init_wr_cnt));
      end_test("free_list");

      for (int i = 0; i < num_tests; i++) begin
         start_test();
         if (tests[i].op == op_wr) begin
            n_wr++;
            cpu_write(tests[i].addr, tests[i].data);
            check_true(mem.exists(tests[i].addr),
                       $sformatf("%s reached no memory write", tests[i].name));
            if (mem.exists(tests[i].addr)) begin
               check_value(tests[i].name, tests[i].expected, mem[tests[i].addr]);
            end
         end else begin
            n_rd++;
            cpu_read(tests[i].addr, rd_resp);
            check_value(tests[i].name, tests[i].expected, rd_resp.data);
            // model always answers okay
            check_value($sformatf("%s resp", tests[i].name), 64'h0, 64'(rd_resp.resp));
         end
         end_test(tests[i].name);
      end

      // one response per request, no stray memory writes
      repeat (4) @(posedge clk_i);
      start_test();
      check_value("resp_counts cpu_bvalid", 64'(n_wr), 64'(cpu_b_cnt));
      check_value("resp_counts cpu_rresp", 64'(n_rd), 64'(cpu_r_cnt));
      check_value("resp_counts mc_wr", 64'(att_entries + num_pages + n_wr), 64'(mc_wr_cnt));
      end_test("resp_counts");

      $display("tests run: %0d, passed: %0d, failed: %0d",
               pass_cnt + fail_cnt, pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

   ////////////////////
   // watchdog
   ////////////////////
   initial begin : watchdog
      cycle_cnt = 0;
      while (cycle_cnt < timeout_cycles) begin
         @(posedge clk_i);
         cycle_cnt++;
      end
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("** FAIL **");
      $finish;
   end

endmodule

// File: files.f
src/hacd_pkg.sv
src/hacd_ctrl_unit.sv
src/hacd_pgwr_mngr.sv
src/hacd_wr_master.sv
src/hacd_mem_mux.sv
src/hacd_core.sv
test/hacd_core_assertions.sv
test/hacd_core_tb.sv
